//--- compile.f
source/capture_pkg.sv
source/trigger_detect.sv
source/channel_window.sv
source/event_store.sv
source/pulse_capture_top.sv
sim/tb_pulse_capture.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pulse_capture -Mdir obj_dir -f compile.f

out=$(./obj_dir/Vtb_pulse_capture) || true
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- sim/pulse_capture_tests.txt
# header: name mode events peak_a tail_a peak_b tail_b (mode 1 keeps hps_read high)
# segment lines after a header: count a_start a_step b_start b_step

single 0 1 -5000 -600 -800 -70
2 100 0 50 0
1 -2500 0 -300 0
5 -3000 -500 -400 -100
22 -4800 200 -700 30

at_threshold 0 1 -2170 -1840 -5 380
1 -2170 0 -5 0
27 -2100 10 900 -20

above_threshold 0 0 0 0 0 0
30 -2169 0 -8000 0

no_retrigger 0 2 -2300 -1000 -60 18
1 -3000 0 0 0
9 -2500 -100 10 1
18 -4000 100 100 -5
1 -2200 0 -50 0
27 -2300 50 -60 3

readout_hold 1 1 -8000 8165 -8192 -8166
1 -8000 0 8000 0
27 8191 -1 -8192 1

late_trigger 0 1 -2171 -1780 -1001 -999
40 500 0 -1000 0
1 -2171 0 -1001 0
27 -1000 -30 -999 0

//--- sim/tb_pulse_capture.sv
`timescale 1ns/1ns

module tb_pulse_capture
    import capture_pkg::*;
();

    localparam int    HALF_PERIOD  = 4;                         // 8 ns sample clock
    localparam int    RESET_CYCLES = 10;
    localparam int    TEST_MARGIN  = 64;                        // gap, drain and readout
    localparam int    IDLE_SPAN    = 8191 - int'(TRIGGER_LEVEL); // levels above threshold
    localparam string TEST_FILE    = "sim/pulse_capture_tests.txt";

    logic               ADA_DCO;
    logic               hps_fpga_reset_n;
    sample_t            ada_d;
    sample_t            adb_d;
    logic               hps_read;
    logic [WORD_W-1:0]  data_peak_out;
    logic [WORD_W-1:0]  data_tail_out;
    time_t              data_time_out;
    logic [COUNT_W-1:0] event_count;

    // test table with one entry per header line of the file
    string t_name [$];
    int    t_mode [$];    // 1 = hps_read held high through the test
    int    t_events [$];  // new events expected
    int    t_pa [$];
    int    t_ta [$];
    int    t_pb [$];
    int    t_tb [$];
    int    t_first [$];   // first segment
    int    t_nseg [$];
    // ramp segments where sample i = start + i * step
    int    s_cnt [$];
    int    s_a0 [$];
    int    s_da [$];
    int    s_b0 [$];
    int    s_db [$];

    int edge_idx;          // rising edge that clocks the next driven sample
    int cycle_count;
    int cycle_limit;
    int errors;
    int tests_failed;
    int total_samples;
    bit m_busy;            // reference window open
    int m_pos;             // samples seen in the window
    int m_start;           // edge of the triggering sample
    int m_min [NUM_CH];
    int m_count;
    int m_store_edge;      // edge that stores the latest event
    int m_peak [NUM_CH];
    int m_tail [NUM_CH];
    int m_time;
    int rd_peak [NUM_CH];  // event the readout should show
    int rd_tail [NUM_CH];
    int rd_time;

    pulse_capture_top i_pulse_capture_top (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .hps_read         (hps_read),
        .data_peak_out    (data_peak_out),
        .data_tail_out    (data_tail_out),
        .data_time_out    (data_time_out),
        .event_count      (event_count)
    );

    initial
    begin
        ADA_DCO = 1'b0;
        forever
            #HALF_PERIOD ADA_DCO = ~ADA_DCO;
    end

    // watchdog limit is set once the test file is loaded
    initial
    begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit)
        begin
            @(posedge ADA_DCO);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int idle_sample();
        return int'(TRIGGER_LEVEL) + 1 + int'($urandom % IDLE_SPAN);  // never triggers
    endfunction

    // one sample pair clocked at edge e
    function automatic void model_step(input int a, input int b, input int e);
        int smp [NUM_CH];
        smp[0] = a;
        smp[1] = b;
        if (!m_busy)
        begin
            if (a <= int'(TRIGGER_LEVEL))  // at or below opens a window
            begin
                m_busy  = 1'b1;
                m_pos   = 1;
                m_start = e;
                m_min   = smp;
            end
        end
        else
        begin
            m_pos++;
            for (int c = 0; c < NUM_CH; c++)
                if (smp[c] < m_min[c])
                    m_min[c] = smp[c];
            if (m_pos == POST_LEN)
            begin
                m_busy       = 1'b0;  // crossings inside were ignored
                m_count++;
                m_store_edge = m_start + POST_LEN + 2;  // stored at edge k+30
                m_peak       = m_min;
                m_tail       = smp;
                m_time       = m_start;
            end
        end
    endfunction

    // channel a in bits 13..0, channel b in bits 29..16
    function automatic logic [WORD_W-1:0] pack_word(input int a, input int b);
        logic [WORD_W-1:0] w;
        w        = '0;
        w[13:0]  = a[13:0];
        w[29:16] = b[13:0];
        return w;
    endfunction

    function automatic void latch_expected();
        rd_peak = m_peak;
        rd_tail = m_tail;
        rd_time = m_time;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus is called on a falling edge and returns on the next one
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input int a, input int b, input logic rd);
        ada_d    = sample_t'(a);
        adb_d    = sample_t'(b);
        hps_read = rd;
        model_step(a, b, edge_idx);
        edge_idx++;
        @(negedge ADA_DCO);
    endtask

    // run idle until the last event has landed in the store
    task automatic drain(input logic rd);
        while (m_busy || edge_idx <= m_store_edge)
            drive_cycle(idle_sample(), idle_sample(), rd);
    endtask

    task automatic read_latest();
        repeat (4)
            drive_cycle(idle_sample(), idle_sample(), 1'b1);  // latched on the third edge
        latch_expected();
        drive_cycle(idle_sample(), idle_sample(), 1'b0);
    endtask

    task automatic check_count();
        assert (event_count == COUNT_W'(m_count))
        else
        begin
            $display("ERROR at %0t ns: event_count %0d, expected %0d", $time, event_count,
                     m_count);
            errors++;
        end
    endtask

    task automatic check_readout();
        logic [WORD_W-1:0] exp_peak;
        logic [WORD_W-1:0] exp_tail;
        exp_peak = pack_word(rd_peak[0], rd_peak[1]);
        exp_tail = pack_word(rd_tail[0], rd_tail[1]);
        assert (data_peak_out == exp_peak)
        else
        begin
            $display("ERROR at %0t ns: data_peak_out %h, expected %h", $time, data_peak_out,
                     exp_peak);
            errors++;
        end
        assert (data_tail_out == exp_tail)
        else
        begin
            $display("ERROR at %0t ns: data_tail_out %h, expected %h", $time, data_tail_out,
                     exp_tail);
            errors++;
        end
        assert (data_time_out == time_t'(rd_time))
        else
        begin
            $display("ERROR at %0t ns: data_time_out %0d, expected %0d", $time, data_time_out,
                     rd_time);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test file and test sequencing
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        string name;
        int    v [6];
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            $display("could not open the test file %s", TEST_FILE);
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %d %d %d %d %d %d", name, v[0], v[1], v[2], v[3], v[4], v[5]);
            if (n == 7)  // header line
            begin
                t_name.push_back(name);
                t_mode.push_back(v[0]);
                t_events.push_back(v[1]);
                t_pa.push_back(v[2]);
                t_ta.push_back(v[3]);
                t_pb.push_back(v[4]);
                t_tb.push_back(v[5]);
                t_first.push_back(s_cnt.size());
                t_nseg.push_back(0);
            end
            else if ($sscanf(line, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]) == 5
                     && t_nseg.size() > 0)
            begin
                s_cnt.push_back(v[0]);
                s_a0.push_back(v[1]);
                s_da.push_back(v[2]);
                s_b0.push_back(v[3]);
                s_db.push_back(v[4]);
                t_nseg[t_nseg.size() - 1]++;
                total_samples += v[0];
            end
            else
            begin
                $display("the test file has a line that cannot be read: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        logic hold;
        int   err_before;
        int   ev_before;
        int   i;
        int   s;
        hold       = (t_mode[t] == 1);
        err_before = errors;
        ev_before  = m_count;
        repeat (4)
            drive_cycle(idle_sample(), idle_sample(), hold);  // hold mode latches old event
        if (hold)
            latch_expected();
        for (s = t_first[t]; s < t_first[t] + t_nseg[t]; s++)
            for (i = 0; i < s_cnt[s]; i++)
                drive_cycle(s_a0[s] + i * s_da[s], s_b0[s] + i * s_db[s], hold);
        drain(hold);
        check_count();
        // reference model against the file's expectations
        assert (m_count - ev_before == t_events[t])
        else
        begin
            $display("ERROR at %0t ns: model made %0d events, file expects %0d", $time,
                     m_count - ev_before, t_events[t]);
            errors++;
        end
        if (t_events[t] > 0)
            assert (m_peak[0] == t_pa[t] && m_tail[0] == t_ta[t] &&
                    m_peak[1] == t_pb[t] && m_tail[1] == t_tb[t])
            else
            begin
                $display("ERROR at %0t ns: model peak/tail %0d %0d %0d %0d disagree with file",
                         $time, m_peak[0], m_tail[0], m_peak[1], m_tail[1]);
                errors++;
            end
        if (hold)
        begin
            repeat (2)
                drive_cycle(idle_sample(), idle_sample(), 1'b1);  // room for a second latch
            check_readout();  // newer event stored but readout unchanged
            drive_cycle(idle_sample(), idle_sample(), 1'b0);
        end
        read_latest();
        check_readout();
        if (errors != err_before)
            tests_failed++;
        $display("test %s: %s", t_name[t], (errors == err_before) ? "passed" : "FAILED");
    endtask

    initial
    begin
        hps_fpga_reset_n = 1'b0;
        ada_d            = '0;
        adb_d            = '0;
        hps_read         = 1'b0;
        errors           = 0;
        tests_failed     = 0;
        total_samples    = 0;
        edge_idx         = 0;
        m_busy           = 1'b0;
        m_count          = 0;
        m_store_edge     = -1;
        m_time           = 0;
        for (int c = 0; c < NUM_CH; c++)
        begin
            m_peak[c] = 0;
            m_tail[c] = 0;
        end
        latch_expected();  // readout is zero after reset
        void'($urandom(64));
        load_tests();
        cycle_limit = RESET_CYCLES + total_samples + TEST_MARGIN * (t_name.size() + 1);

        repeat (RESET_CYCLES) @(posedge ADA_DCO);
        @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;  // next rising edge is edge 0

        repeat (4)
            drive_cycle(idle_sample(), idle_sample(), 1'b0);
        begin
            int err_before;
            err_before = errors;
            check_count();
            check_readout();
            if (errors != err_before)
                tests_failed++;
            $display("test %s: %s", "after_reset", (errors == err_before) ? "passed" : "FAILED");
        end

        for (int t = 0; t < t_name.size(); t++)
            run_test(t);

        $display("%0d tests run, %0d failed, %0d errors", t_name.size() + 1, tests_failed,
                 errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- source/capture_pkg.sv
package capture_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // adc sample format
    ////////////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 14;                  // adc data bits per channel
    typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement adc word

    localparam int NUM_CH = 2;                     // 0 = channel a, 1 = channel b

    ////////////////////////////////////////////////////////////////////////////
    // trigger and window
    ////////////////////////////////////////////////////////////////////////////

    localparam int POST_LEN = 28;                  // samples after the trigger
    localparam int POS_W    = $clog2(POST_LEN);    // window position counter

    // channel a at or below this opens a window
    localparam sample_t TRIGGER_LEVEL = -14'sd2170;

    ////////////////////////////////////////////////////////////////////////////
    // time stamp and readout
    ////////////////////////////////////////////////////////////////////////////

    localparam int TIME_W = 26;                    // free running time base
    typedef logic [TIME_W-1:0] time_t;

    localparam int WORD_W      = 32;               // processor word
    localparam int LANE_OFFSET = 16;               // channel b starts here

    localparam int COUNT_W = 16;                   // event counter, wraps

endpackage

//--- source/channel_window.sv
`timescale 1ns/1ns

module channel_window
    import capture_pkg::*;
(
    input  logic    ADA_DCO,
    input  logic    hps_fpga_reset_n,
    input  sample_t win_sample,
    input  logic    win_first,
    input  logic    win_active,
    input  logic    win_last,
    output sample_t peak,
    output sample_t tail,
    output logic    ch_done
);

    ////////////////////////////////////////////////////////////////////////////
    // running minimum over the window
    ////////////////////////////////////////////////////////////////////////////

    sample_t run_min;   // most negative so far
    sample_t next_min;  // includes the current sample

    // signed compare, pulses go negative
    always_comb
    begin
        next_min = (win_sample < run_min) ? win_sample : run_min;
    end

    always_ff @(posedge ADA_DCO)
    begin
        if (win_first)
            run_min <= win_sample;  // restart on each window
        else if (win_active)
            run_min <= next_min;

        // results held until the next window closes
        if (win_last)
        begin
            peak <= next_min;
            tail <= win_sample;  // last sample of the window
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // completion strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            ch_done <= 1'b0;
        else
            ch_done <= win_last;  // same cycle as peak and tail
    end

    // the window must open together with its first sample
    a_first_in_window : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        win_first |-> win_active);

endmodule

//--- source/event_store.sv
`timescale 1ns/1ns

module event_store
    import capture_pkg::*;
(
    input  logic               ADA_DCO,
    input  logic               hps_fpga_reset_n,
    input  sample_t            peak [NUM_CH],
    input  sample_t            tail [NUM_CH],
    input  logic [NUM_CH-1:0]  ch_done,
    input  time_t              win_time,
    input  logic               hps_read,
    output logic [WORD_W-1:0]  data_peak_out,
    output logic [WORD_W-1:0]  data_tail_out,
    output time_t              data_time_out,
    output logic [COUNT_W-1:0] event_count
);

    sample_t           ev_peak [NUM_CH];  // latest event
    sample_t           ev_tail [NUM_CH];
    time_t             ev_time;
    logic [2:0]        read_pipe;         // hps_read history
    logic              read_rise;
    logic [WORD_W-1:0] peak_word;
    logic [WORD_W-1:0] tail_word;

    ////////////////////////////////////////////////////////////////////////////
    // latest event
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            for (int i = 0; i < NUM_CH; i++)
            begin
                ev_peak[i] <= '0;
                ev_tail[i] <= '0;
            end
            ev_time     <= '0;
            event_count <= '0;
        end
        else if (ch_done[0])  // channels finish together
        begin
            for (int i = 0; i < NUM_CH; i++)
            begin
                ev_peak[i] <= peak[i];
                ev_tail[i] <= tail[i];
            end
            ev_time     <= win_time;
            event_count <= event_count + COUNT_W'(1);  // wraps at full scale
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // processor readout
    ////////////////////////////////////////////////////////////////////////////

    // one lane per channel, unused bits stay zero
    always_comb
    begin
        peak_word = '0;
        tail_word = '0;
        for (int i = 0; i < NUM_CH; i++)
        begin
            peak_word[i*LANE_OFFSET +: SAMPLE_W] = ev_peak[i];
            tail_word[i*LANE_OFFSET +: SAMPLE_W] = ev_tail[i];
        end
    end

    assign read_rise = read_pipe[1] & ~read_pipe[2];  // one pulse per read

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            read_pipe     <= '0;
            data_peak_out <= '0;
            data_tail_out <= '0;
            data_time_out <= '0;
        end
        else
        begin
            read_pipe <= {read_pipe[1:0], hps_read};
            if (read_rise)
            begin
                data_peak_out <= peak_word;
                data_tail_out <= tail_word;
                data_time_out <= ev_time;
            end
        end
    end

    a_done_aligned : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        (ch_done == '0) || (ch_done == '1));

endmodule

//--- source/pulse_capture_top.sv
`timescale 1ns/1ns

module pulse_capture_top
    import capture_pkg::*;
(
    input  logic               ADA_DCO,
    input  logic               hps_fpga_reset_n,
    input  sample_t            ada_d,
    input  sample_t            adb_d,
    input  logic               hps_read,
    output logic [WORD_W-1:0]  data_peak_out,
    output logic [WORD_W-1:0]  data_tail_out,
    output time_t              data_time_out,
    output logic [COUNT_W-1:0] event_count
);

    sample_t           win_sample [NUM_CH];  // aligned window samples
    logic              win_first;
    logic              win_active;
    logic              win_last;
    time_t             win_time;
    sample_t           peak [NUM_CH];        // per channel results
    sample_t           tail [NUM_CH];
    logic [NUM_CH-1:0] ch_done;

    // threshold on channel a drives both channels
    trigger_detect i_trigger_detect (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .win_sample       (win_sample),
        .win_first        (win_first),
        .win_active       (win_active),
        .win_last         (win_last),
        .win_time         (win_time)
    );

    for (genvar i = 0; i < NUM_CH; i++)
    begin : g_ch
        channel_window i_channel_window (
            .ADA_DCO          (ADA_DCO),
            .hps_fpga_reset_n (hps_fpga_reset_n),
            .win_sample       (win_sample[i]),
            .win_first        (win_first),
            .win_active       (win_active),
            .win_last         (win_last),
            .peak             (peak[i]),
            .tail             (tail[i]),
            .ch_done          (ch_done[i])
        );
    end

    event_store i_event_store (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .peak             (peak),
        .tail             (tail),
        .ch_done          (ch_done),
        .win_time         (win_time),
        .hps_read         (hps_read),
        .data_peak_out    (data_peak_out),
        .data_tail_out    (data_tail_out),
        .data_time_out    (data_time_out),
        .event_count      (event_count)
    );

endmodule

//--- source/trigger_detect.sv
`timescale 1ns/1ns

module trigger_detect
    import capture_pkg::*;
(
    input  logic    ADA_DCO,
    input  logic    hps_fpga_reset_n,
    input  sample_t ada_d,
    input  sample_t adb_d,
    output sample_t win_sample [NUM_CH],
    output logic    win_first,
    output logic    win_active,
    output logic    win_last,
    output time_t   win_time
);

    sample_t          samp_q [NUM_CH];  // input register, one per channel
    time_t            time_q;           // time stamp aligned with samp_q
    time_t            time_cnt;         // free running
    time_t            trig_time;        // stamp of the open window
    logic             busy;             // window open
    logic [POS_W-1:0] pos;              // samples already sent

    logic trig;
    assign trig = !busy && (samp_q[0] <= TRIGGER_LEVEL);  // only looked at when idle

    // sample capture and window payload
    always_ff @(posedge ADA_DCO)
    begin
        samp_q[0]  <= ada_d;
        samp_q[1]  <= adb_d;
        time_q     <= time_cnt;
        win_sample <= samp_q;
        if (trig)
            trig_time <= time_q;
        if (busy && pos == POS_W'(POST_LEN - 1))
            win_time <= trig_time;  // held until the next window closes
    end

    // time base and window sequencing
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            time_cnt   <= '0;
            busy       <= 1'b0;
            pos        <= '0;
            win_first  <= 1'b0;
            win_active <= 1'b0;
            win_last   <= 1'b0;
        end
        else
        begin
            time_cnt  <= time_cnt + 1'b1;
            win_first <= trig;
            if (trig)
            begin
                busy       <= 1'b1;
                pos        <= POS_W'(1);  // triggering sample is the first one
                win_active <= 1'b1;
                win_last   <= 1'b0;
            end
            else if (busy)
            begin
                pos        <= pos + 1'b1;
                win_active <= 1'b1;
                win_last   <= (pos == POS_W'(POST_LEN - 1));
                if (pos == POS_W'(POST_LEN - 1))
                    busy <= 1'b0;  // rearm for the next sample
            end
            else
            begin
                win_active <= 1'b0;
                win_last   <= 1'b0;
            end
        end
    end

    a_first_not_last : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        !(win_first && win_last));
    a_last_in_window : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        win_last |-> win_active);

endmodule
